/* tb/branchInput.txt */
// {clear,accept} lastValid _ fetchPc _ halfwords 7..0 _ redirTaken redirOffs _ redirDst _ retAct histAct
// _ endOffsValid endOffs _ retPushValid _ retPushAddr _ btValid btType _ btSrc _ btDst _ btCompr btStartOffs
07_00001000_0000_0000_0000_0000_0000_0000_0000_0000_00_00000000_00_00_0_00000000_00_00000000_00000000_00
17_00001000_0001_0001_0001_0001_0001_A021_0001_0001_12_00000806_00_13_0_00000000_10_00001004_0000100C_10
17_00001000_0001_0001_0100_006F_0001_0001_0001_0001_15_0000080C_00_16_0_00000000_10_0000100A_00001018_00
17_00001000_0001_0001_0001_0001_0001_0001_C011_0001_11_00000802_01_12_0_00000000_12_00001002_00001006_10
17_00001000_0001_0001_0001_0000_0463_0001_0001_0001_14_00000805_01_15_0_00000000_12_00001008_0000100E_00
17_00001000_0001_0001_0001_0000_2463_0001_0001_0001_00_00000000_00_00_0_00000000_00_00000000_00000000_00
17_00001000_006F_0001_0001_0001_0001_0001_0001_0001_00_00000000_00_00_0_00000000_00_00000000_00000000_00
17_00001010_0001_0001_0001_0001_0001_0001_0001_0100_10_0000080F_00_11_0_00000000_10_00001010_0000101E_00
17_00001000_006F_0001_0001_0001_0001_0001_0001_0001_00_00000000_00_00_0_00000000_00_00000000_00000000_00
27_00001000_0001_0001_0001_0001_0001_0001_0001_0001_00_00000000_00_00_0_00000000_00_00000000_00000000_00
17_00001010_0001_0001_0001_0001_0001_0001_0001_0100_00_00000000_00_00_0_00000000_00_00000000_00000000_00
15_00001006_0001_C011_0001_0001_0001_0001_A021_0001_00_00000000_00_00_0_00000000_00_00000000_00000000_00
17_00001000_0001_0001_C011_0001_0001_A021_0001_0001_12_00000806_00_13_0_00000000_10_00001004_0000100C_10
17_00001000_0001_0001_0001_0001_2021_0001_0001_0001_13_00000807_10_14_1_00000803_11_00001006_0000100E_10
17_00001000_0001_0001_0001_0001_0001_0001_0003_00E7_11_00000802_10_12_1_00000801_00_00000000_00000000_00
17_00001000_0001_0001_0001_8082_0001_0001_0001_0001_00_00000000_00_00_0_00000000_13_00001008_00000000_10
17_00001000_A021_0001_0001_0001_0001_0001_0001_0001_17_0000080B_00_00_0_00000000_10_0000100E_00001016_10
37_00001000_0001_0001_0001_0001_0001_A021_0001_0001_12_00000806_00_13_0_00000000_00_00000000_00000000_00
07_00001000_0001_0001_0001_0001_0001_0001_0001_0001_00_00000000_00_00_0_00000000_00_00000000_00000000_00

/* files.f */
common/fetchPkg.sv
common/slotIf.sv
common/candIf.sv
logic/boundaryScan.sv
logic/branchDecode.sv
logic/redirectSelect.sv
logic/branchHandler.sv
tb/branchHandler_properties.sv
tb/branchHandlerTb.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f files.f --top-module branchHandlerTb -o simv
	-./obj_dir/simv > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "TEST FAILED"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
		echo "TEST FAILED"; exit 1; \
	else \
		echo "TEST PASSED"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* tb/branchHandlerTb.sv */
module branchHandlerTb;
    import fetchPkg::*;

    localparam int resetCycles = 10;
    localparam int maxVectors = 64;

    logic clk;
    logic rst;
    logic clear;
    logic accept;
    addrT fetchPc;
    fetchOffT lastValid;
    halfT [numInst-1:0] instrs;

    logic redirTaken;
    fetchOffT redirOffs;
    halfAddrT redirDst;
    retActT retAct;
    histActT histAct;
    logic endOffsValid;
    fetchOffT endOffs;
    logic retPushValid;
    halfAddrT retPushAddr;
    logic btValid;
    brTypeT btType;
    addrT btSrc;
    addrT btDst;
    logic btCompr;
    fetchOffT btStartOffs;

    // One line per cycle with fields packed from the control digit down to the buffer update
    logic [339:0] vectors [0:maxVectors-1];
    int vecCount;
    int cycles;

    branchHandler dut0 (
        .clk          (clk),
        .rst          (rst),
        .clear        (clear),
        .accept       (accept),
        .fetchPc      (fetchPc),
        .lastValid    (lastValid),
        .instrs       (instrs),
        .redirTaken   (redirTaken),
        .redirOffs    (redirOffs),
        .redirDst     (redirDst),
        .retAct       (retAct),
        .histAct      (histAct),
        .endOffsValid (endOffsValid),
        .endOffs      (endOffs),
        .retPushValid (retPushValid),
        .retPushAddr  (retPushAddr),
        .btValid      (btValid),
        .btType       (btType),
        .btSrc        (btSrc),
        .btDst        (btDst),
        .btCompr      (btCompr),
        .btStartOffs  (btStartOffs)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Compare one output and stop at the first mismatch
    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected) begin
            $display("error at time %0t: %s expected %0h actual %0h",
                     $time, name, expected, actual);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic applyInputs(input logic [339:0] v);
        clear     = v[337];
        accept    = v[336];
        lastValid = v[334:332];
        fetchPc   = v[331:300];
        instrs    = v[299:172];
    endtask

    task automatic expectRedirect(input logic [339:0] v);
        checkValue("redirTaken", 64'(v[168]), 64'(redirTaken));
        checkValue("redirOffs", 64'(v[166:164]), 64'(redirOffs));
        checkValue("redirDst", 64'(v[162:132]), 64'(redirDst));
        checkValue("retAct", 64'(v[129:128]), 64'(retAct));
        checkValue("histAct", 64'(v[125:124]), 64'(histAct));
        checkValue("endOffsValid", 64'(v[120]), 64'(endOffsValid));
        checkValue("endOffs", 64'(v[118:116]), 64'(endOffs));
        checkValue("retPushValid", 64'(v[112]), 64'(retPushValid));
        checkValue("retPushAddr", 64'(v[110:80]), 64'(retPushAddr));
    endtask

    // Buffer fields only matter when an entry is expected
    task automatic verifyBuffer(input logic [339:0] v);
        checkValue("btValid", 64'(v[76]), 64'(btValid));
        if (v[76]) begin
            checkValue("btType", 64'(v[73:72]), 64'(btType));
            checkValue("btSrc", 64'(v[71:40]), 64'(btSrc));
            checkValue("btDst", 64'(v[39:8]), 64'(btDst));
            checkValue("btCompr", 64'(v[4]), 64'(btCompr));
            checkValue("btStartOffs", 64'(v[2:0]), 64'(btStartOffs));
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > vecCount + resetCycles + 20) begin
            $display("Test did not finish in time");
            $display("Finished with errors");
            $fatal(1);
        end
    end

    initial begin
        cycles    = 0;
        vecCount  = 0;
        rst       = 1'b1;
        clear     = 1'b0;
        accept    = 1'b0;
        fetchPc   = '0;
        lastValid = '0;
        instrs    = '0;

        // Unused entries keep an impossible control digit
        for (int i = 0; i < maxVectors; i++)
            vectors[i] = '1;
        $readmemh("tb/branchInput.txt", vectors);
        while (vecCount < maxVectors && vectors[vecCount][339:336] != 4'hF)
            vecCount++;
        if (vecCount == 0) begin
            $display("No stimulus vectors could be read");
            $display("Finished with errors");
            $fatal(1);
        end

        repeat (resetCycles) @(negedge clk);
        rst = 1'b0;

        for (int n = 0; n < vecCount; n++) begin
            @(negedge clk);
            applyInputs(vectors[n]);
            #10;
            expectRedirect(vectors[n]);
            if (n == 0)
                checkValue("btValid", 64'(0), 64'(btValid));
            else
                verifyBuffer(vectors[n-1]);
        end

        // One idle cycle to see the last buffer update
        @(negedge clk);
        accept = 1'b0;
        clear  = 1'b0;
        #10;
        verifyBuffer(vectors[vecCount-1]);

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* tb/branchHandler_properties.sv */
module branchHandlerProperties (
    input logic clk,
    input logic rst,
    input logic clear,
    input logic accept,
    input logic redirTaken,
    input logic endOffsValid,
    input logic btValid
);

    // Buffer update belongs to an accepted package that was not cleared
    assert property (@(posedge clk) disable iff (rst)
        btValid |-> $past(accept && !clear))
        else $error("btValid without an accepted package in the cycle before");

    assert property (@(posedge clk) disable iff (rst)
        endOffsValid |-> redirTaken)
        else $error("endOffsValid without redirTaken");

    assert property (@(posedge clk) disable iff (rst)
        redirTaken |-> accept)
        else $error("redirTaken without accept");

    // Nothing is registered during reset
    assert property (@(posedge clk)
        $fell(rst) |-> !btValid)
        else $error("btValid set right after reset");

endmodule

bind branchHandler branchHandlerProperties props0 (
    .clk          (clk),
    .rst          (rst),
    .clear        (clear),
    .accept       (accept),
    .redirTaken   (redirTaken),
    .endOffsValid (endOffsValid),
    .btValid      (btValid)
);

/* logic/branchHandler.sv */
module branchHandler (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic accept,
    input  fetchPkg::addrT fetchPc,
    input  fetchPkg::fetchOffT lastValid,
    input  fetchPkg::halfT [fetchPkg::numInst-1:0] instrs,

    output logic redirTaken,
    output fetchPkg::fetchOffT redirOffs,
    output fetchPkg::halfAddrT redirDst,
    output fetchPkg::retActT retAct,
    output fetchPkg::histActT histAct,

    output logic endOffsValid,
    output fetchPkg::fetchOffT endOffs,

    output logic retPushValid,
    output fetchPkg::halfAddrT retPushAddr,

    output logic btValid,
    output fetchPkg::brTypeT btType,
    output fetchPkg::addrT btSrc,
    output fetchPkg::addrT btDst,
    output logic btCompr,
    output fetchPkg::fetchOffT btStartOffs
);

    slotIf slotBus ();
    candIf candBus ();

    boundaryScan scanner (
        .clk        (clk),
        .rst        (rst),
        .clear      (clear),
        .accept     (accept),
        .redirTaken (redirTaken),
        .fetchPc    (fetchPc),
        .lastValid  (lastValid),
        .instrs     (instrs),
        .slots      (slotBus.source)
    );

    branchDecode decoder (
        .slots (slotBus.sink),
        .cands (candBus.source)
    );

    redirectSelect selector (
        .clk          (clk),
        .rst          (rst),
        .clear        (clear),
        .accept       (accept),
        .fetchPc      (fetchPc),
        .lastValid    (lastValid),
        .cands        (candBus.sink),
        .redirTaken   (redirTaken),
        .redirOffs    (redirOffs),
        .redirDst     (redirDst),
        .retAct       (retAct),
        .histAct      (histAct),
        .endOffsValid (endOffsValid),
        .endOffs      (endOffs),
        .retPushValid (retPushValid),
        .retPushAddr  (retPushAddr),
        .btValid      (btValid),
        .btType       (btType),
        .btSrc        (btSrc),
        .btDst        (btDst),
        .btCompr      (btCompr),
        .btStartOffs  (btStartOffs)
    );

endmodule

/* logic/redirectSelect.sv */
module redirectSelect (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic accept,
    input  fetchPkg::addrT fetchPc,
    input  fetchPkg::fetchOffT lastValid,
    candIf.sink cands,

    output logic redirTaken,
    output fetchPkg::fetchOffT redirOffs,
    output fetchPkg::halfAddrT redirDst,
    output fetchPkg::retActT retAct,
    output fetchPkg::histActT histAct,

    output logic endOffsValid,
    output fetchPkg::fetchOffT endOffs,

    output logic retPushValid,
    output fetchPkg::halfAddrT retPushAddr,

    output logic btValid,
    output fetchPkg::brTypeT btType,
    output fetchPkg::addrT btSrc,
    output fetchPkg::addrT btDst,
    output logic btCompr,
    output fetchPkg::fetchOffT btStartOffs
);
    import fetchPkg::*;

    fetchOffT startOffs;

    logic     redirTakenC;
    fetchOffT redirOffsC;
    halfAddrT redirDstC;
    retActT   retActC;
    histActT  histActC;
    logic     endOffsValidC;
    fetchOffT endOffsC;
    logic     retPushValidC;
    halfAddrT retPushAddrC;
    logic     btValidC;
    brTypeT   btTypeC;
    addrT     btSrcC;
    addrT     btDstC;
    logic     btComprC;

    assign startOffs = fetchPc[1 +: fetchOffBits];

    // First acting branch in slot order wins
    always_comb begin
        redirTakenC   = 1'b0;
        redirOffsC    = '0;
        redirDstC     = '0;
        retActC       = retNone;
        histActC      = histNone;
        endOffsValidC = 1'b0;
        endOffsC      = '0;
        retPushValidC = 1'b0;
        retPushAddrC  = '0;
        btValidC      = 1'b0;
        btTypeC       = btJump;
        btSrcC        = '0;
        btDstC        = '0;
        btComprC      = 1'b0;

        for (int i = 0; i < numInst; i++) begin
            brKindT k;
            fetchOffT fhOffs;
            halfAddrT nextPc;

            k      = cands.kind[i];
            fhOffs = cands.fhPc[i][1 +: fetchOffBits];
            nextPc = {fetchPc[31:fetchOffBits+1], fetchOffT'(i)} + 31'd1;

            if (!redirTakenC && cands.valid[i] &&
                fetchOffT'(i) >= startOffs && fetchOffT'(i) <= lastValid) begin
                if (k == jump || k == call) begin
                    redirTakenC = 1'b1;
                    redirDstC   = cands.target[i][31:1];
                    retActC     = (k == call) ? retPush : retNone;
                end else if (k == branch || k == iCall) begin
                    // Refetch after the branch so the history gets corrected
                    redirTakenC = 1'b1;
                    redirDstC   = nextPc;
                    retActC     = (k == iCall) ? retPush : retNone;
                    histActC    = (k == branch) ? histAppend0 : histNone;
                end

                if (redirTakenC) begin
                    redirOffsC = fetchOffT'(i);
                    if (fhOffs != '1) begin
                        endOffsValidC = 1'b1;
                        endOffsC      = fhOffs + 1'b1;
                    end
                end

                if (!btValidC && k != iJump && k != iCall) begin
                    btValidC = 1'b1;
                    btTypeC  = k[2:1];
                    btSrcC   = cands.fhPc[i];
                    btDstC   = cands.target[i];
                    btComprC = cands.compr[i];
                end

                if (k == call || k == iCall) begin
                    retPushValidC = 1'b1;
                    retPushAddrC  = {fetchPc[31:fetchOffBits+1], fhOffs};
                end
            end
        end
    end

    always_comb begin
        redirTaken   = 1'b0;
        redirOffs    = '0;
        redirDst     = '0;
        retAct       = retNone;
        histAct      = histNone;
        endOffsValid = 1'b0;
        endOffs      = '0;
        retPushValid = 1'b0;
        retPushAddr  = '0;
        if (accept) begin
            redirTaken   = redirTakenC;
            redirOffs    = redirOffsC;
            redirDst     = redirDstC;
            retAct       = retActC;
            histAct      = histActC;
            endOffsValid = endOffsValidC;
            endOffs      = endOffsC;
            retPushValid = retPushValidC;
            retPushAddr  = retPushAddrC;
        end
    end

    // Buffer update goes out one cycle after the package
    always_ff @(posedge clk) begin
        if (rst) begin
            btValid <= 1'b0;
        end else begin
            btValid <= accept && !clear && btValidC;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            btType      <= btTypeC;
            btSrc       <= btSrcC;
            btDst       <= btDstC;
            btCompr     <= btComprC;
            btStartOffs <= startOffs;
        end
    end

endmodule

/* logic/branchDecode.sv */
module branchDecode (
    slotIf.sink   slots,
    candIf.source cands
);
    import fetchPkg::*;

    // Targets for every possible instruction start
    addrT cjTarget [1:numInst];
    addrT cbTarget [1:numInst];
    addrT jTarget  [0:numInst-1];
    addrT bTarget  [0:numInst-1];

    always_comb begin
        for (int i = 1; i <= numInst; i++) begin
            halfT h;

            h = slots.halves[i];
            // c.j and c.jal offset
            cjTarget[i] = slots.slotPc[i] + {{20{h[12]}}, h[12], h[8], h[10:9], h[6],
                                             h[7], h[2], h[11], h[5:3], 1'b0};
            // c.beqz and c.bnez offset
            cbTarget[i] = slots.slotPc[i] + {{23{h[12]}}, h[12], h[6:5], h[2],
                                             h[11:10], h[4:3], 1'b0};
        end

        for (int i = 0; i < numInst; i++) begin
            logic [31:0] w;

            w = {slots.halves[i+1], slots.halves[i]};
            jTarget[i] = slots.slotPc[i] + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            bTarget[i] = slots.slotPc[i] + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        end
    end

    // Candidate i is indexed by the offset of its final halfword
    always_comb begin
        for (int i = 0; i < numInst; i++) begin
            halfT h;
            logic [31:0] w;
            logic rdLink;
            logic rs1Link;

            h = slots.halves[i+1];
            w = {slots.halves[i+1], slots.halves[i]};
            rdLink  = (w[11:7] == 5'd1) || (w[11:7] == 5'd5);
            rs1Link = (w[19:15] == 5'd1) || (w[19:15] == 5'd5);

            cands.valid[i]  = 1'b0;
            cands.kind[i]   = jump;
            cands.compr[i]  = 1'b0;
            cands.target[i] = '0;
            cands.fhPc[i]   = slots.slotPc[i+1];

            if (slots.start16[i+1]) begin
                cands.compr[i] = 1'b1;
                casez (h)
                    16'b001???????????01, 16'b101???????????01: begin
                        // c.jal and c.j
                        cands.valid[i]  = 1'b1;
                        cands.kind[i]   = (h[15:13] == 3'b001) ? call : jump;
                        cands.target[i] = cjTarget[i+1];
                    end
                    16'b1000?????0000010: begin
                        // c.jr with a link source is a return
                        cands.valid[i] = (h[11:7] != 5'd0);
                        cands.kind[i]  = (h[11:7] == 5'd1 || h[11:7] == 5'd5) ? ret : iJump;
                    end
                    16'b1001?????0000010: begin
                        // c.jalr when rs1 is not zero
                        cands.valid[i] = (h[11:7] != 5'd0);
                        cands.kind[i]  = iCall;
                    end
                    16'b11????????????01: begin
                        // c.beqz and c.bnez
                        cands.valid[i]  = 1'b1;
                        cands.kind[i]   = branch;
                        cands.target[i] = cbTarget[i+1];
                    end
                    default: ;
                endcase
            end else if (slots.start32[i]) begin
                case (w[6:0])
                    7'b1101111: begin
                        // jal
                        cands.valid[i]  = 1'b1;
                        cands.kind[i]   = rdLink ? call : jump;
                        cands.target[i] = jTarget[i];
                    end
                    7'b1100111: begin
                        // jalr
                        cands.valid[i] = (w[14:12] == 3'b000);
                        if (rdLink && !(rs1Link && w[19:15] != w[11:7]))
                            cands.kind[i] = iCall;
                        else if (rs1Link && !rdLink)
                            cands.kind[i] = ret;
                        else
                            cands.kind[i] = iJump;
                    end
                    7'b1100011: begin
                        // Funct3 values 2 and 3 are not branches
                        cands.valid[i]  = (w[14:13] != 2'b01);
                        cands.kind[i]   = branch;
                        cands.target[i] = bTarget[i];
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* logic/boundaryScan.sv */
module boundaryScan (
    input  logic clk,
    input  logic rst,
    input  logic clear,
    input  logic accept,
    input  logic redirTaken,
    input  fetchPkg::addrT fetchPc,
    input  fetchPkg::fetchOffT lastValid,
    input  fetchPkg::halfT [fetchPkg::numInst-1:0] instrs,
    slotIf.source slots
);
    import fetchPkg::*;

    // First half of a 32-bit instruction split over two packages
    halfT carryHalf;
    addrT carryPc;
    logic carryValid;

    fetchOffT firstValid;
    logic [fetchOffBits:0] lastIdx;

    // A held carry means the package continues the carried instruction
    assign firstValid = carryValid ? '0 : fetchPc[1 +: fetchOffBits];

    // Slot index of the last valid halfword
    assign lastIdx = {1'b0, lastValid} + 1'b1;

    always_comb begin
        slots.halves[0] = carryHalf;
        slots.slotPc[0] = carryPc;
        for (int i = 1; i <= numInst; i++) begin
            slots.halves[i] = instrs[i-1];
            slots.slotPc[i] = {fetchPc[31:fetchOffBits+1], fetchOffT'(i - 1), 1'b0};
        end
    end

    // Walk the halfwords and mark where instructions start
    always_comb begin
        logic validStart;

        validStart = 1'b0;
        slots.start16 = '0;
        slots.start32 = '0;
        slots.start32[0] = carryValid;

        for (int i = 1; i <= numInst; i++) begin
            if (fetchOffT'(i - 1) < firstValid)
                validStart = 1'b0;
            if (fetchOffT'(i - 1) == firstValid && !carryValid)
                validStart = 1'b1;
            if (fetchOffT'(i - 1) > lastValid)
                validStart = 1'b0;

            if (validStart) begin
                if (slots.halves[i][1:0] == 2'b11) begin
                    slots.start32[i] = 1'b1;
                    // Next halfword is the tail
                    validStart = 1'b0;
                end else begin
                    slots.start16[i] = 1'b1;
                end
            end else begin
                // After a tail or an unused halfword the next one may start again
                validStart = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            carryValid <= 1'b0;
        end else if (clear) begin
            carryValid <= 1'b0;
        end else if (accept) begin
            carryValid <= slots.start32[lastIdx] && !redirTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            carryHalf <= slots.halves[lastIdx];
            carryPc   <= slots.slotPc[lastIdx];
        end
    end

endmodule

/* common/candIf.sv */
interface candIf;
    import fetchPkg::*;

    // Candidate i ends at package offset i
    logic   [numInst-1:0] valid;
    brKindT [numInst-1:0] kind;
    logic   [numInst-1:0] compr;
    addrT   [numInst-1:0] target;

    // Address of the final halfword of the instruction
    addrT   [numInst-1:0] fhPc;

    modport source (
        output valid,
        output kind,
        output compr,
        output target,
        output fhPc
    );

    modport sink (
        input valid,
        input kind,
        input compr,
        input target,
        input fhPc
    );

endinterface

/* common/slotIf.sv */
interface slotIf;
    import fetchPkg::*;

    // Slot 0 is the carried halfword, slots 1 to numInst are the package
    halfT [numInst:0] halves;

    // Instruction start flags per slot
    logic [numInst:0] start16;
    logic [numInst:0] start32;

    // Byte address of each slot
    addrT [numInst:0] slotPc;

    modport source (
        output halves,
        output start16,
        output start32,
        output slotPc
    );

    modport sink (
        input halves,
        input start16,
        input start32,
        input slotPc
    );

endinterface

/* common/fetchPkg.sv */
package fetchPkg;

    // Halfwords per fetch package
    localparam int numInst = 8;

    // Width of a halfword index inside one package
    localparam int fetchOffBits = $clog2(numInst);

    typedef logic [fetchOffBits-1:0] fetchOffT;

    // Byte address
    typedef logic [31:0] addrT;

    // Byte address without bit 0
    typedef logic [30:0] halfAddrT;

    // One instruction halfword
    typedef logic [15:0] halfT;

    // Branch kind as seen by the decoder
    // Bit 0 marks an indirect branch, bits 2:1 give the simple kind
    typedef enum logic [2:0] {
        jump   = 3'd0,
        iJump  = 3'd1,
        call   = 3'd2,
        iCall  = 3'd3,
        branch = 3'd4,
        ret    = 3'd7
    } brKindT;

    // Simple kind registered in the branch target buffer
    typedef logic [1:0] brTypeT;

    localparam brTypeT btJump   = 2'd0;
    localparam brTypeT btCall   = 2'd1;
    localparam brTypeT btBranch = 2'd2;
    localparam brTypeT btRet    = 2'd3;

    // Return stack action that goes with a redirect
    typedef enum logic [1:0] {
        retNone = 2'd0,
        retPush = 2'd1,
        retPop  = 2'd2
    } retActT;

    // Global history action that goes with a redirect
    typedef enum logic [1:0] {
        histNone    = 2'd0,
        histAppend0 = 2'd1,
        histAppend1 = 2'd2
    } histActT;

endpackage
